// File: src/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// register data width
`define EX_DATA_W 32

// shift amount taken from the low bits of operand 1
`define EX_SHAMT_W 5

// destination register address width
`define EX_REGADDR_W 5

// all-zero data word
`define EX_ZERO_WORD {`EX_DATA_W{1'b0}}

`endif

// File: src/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    // decoded alu opcodes, immediate forms map onto the register forms
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        // logic
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        // shift
        OP_SLL,
        OP_SRL,
        OP_SRA,
        // arithmetic
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        // move
        OP_MOVZ,
        OP_MOVN,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        // multiply
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        // register-form traps
        OP_TEQ,
        OP_TNE,
        OP_TGE,
        OP_TGEU,
        OP_TLT,
        OP_TLTU
    } aluop_e;

    // multiply-accumulate phase
    typedef enum logic {
        MAC_MUL = 1'b0,
        MAC_ACC = 1'b1
    } mac_state_e;

    typedef struct packed {
        aluop_e                   aluop;
        logic [`EX_DATA_W-1:0]    reg1;
        logic [`EX_DATA_W-1:0]    reg2;
        logic [`EX_REGADDR_W-1:0] wd;
        logic                     wreg;
    } ex_op_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0]    wdata;
        logic [`EX_REGADDR_W-1:0] wd;
        logic                     wreg;
    } ex_wb_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0] hi;
        logic [`EX_DATA_W-1:0] lo;
    } hilo_t;

    typedef struct packed {
        logic trap;
        logic overflow;
    } ex_except_t;

endpackage

// File: src/alu_logic_shift.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_logic_shift
    import ex_pkg::*;
(
    input  aluop_e                aluop_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    output logic [`EX_DATA_W-1:0] logic_res_o,
    output logic [`EX_DATA_W-1:0] shift_res_o
);

    logic [`EX_SHAMT_W-1:0] shamt;

    // shift amount comes from operand 1, value from operand 2
    assign shamt = reg1_i[`EX_SHAMT_W-1:0];

    always_comb
    begin
        case (aluop_i)
            OP_AND:  logic_res_o = reg1_i & reg2_i;
            OP_OR:   logic_res_o = reg1_i | reg2_i;
            OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
            OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
            default: logic_res_o = `EX_ZERO_WORD;
        endcase
    end

    always_comb
    begin
        case (aluop_i)
            OP_SLL:
            begin
                shift_res_o = reg2_i << shamt;
            end
            OP_SRL:
            begin
                shift_res_o = reg2_i >> shamt;
            end
            OP_SRA:
            begin
                // sign bit fills from the left
                shift_res_o = $signed(reg2_i) >>> shamt;
            end
            default:
            begin
                shift_res_o = `EX_ZERO_WORD;
            end
        endcase
    end

endmodule

// File: src/alu_arith.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu_arith
    import ex_pkg::*;
(
    input  aluop_e                aluop_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    output logic [`EX_DATA_W-1:0] arith_res_o,
    output logic                  ovf_o,
    output logic                  trap_o
);

    localparam int MSB = `EX_DATA_W - 1;

    logic [`EX_DATA_W-1:0] sum;
    logic [`EX_DATA_W-1:0] diff;
    logic                  borrow;
    logic                  ovf_add;
    logic                  ovf_sub;
    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;

    // one adder and one subtractor shared by all compares
    assign sum             = reg1_i + reg2_i;
    assign {borrow, diff}  = {1'b0, reg1_i} - {1'b0, reg2_i};

    // operands of equal sign, result sign flipped
    assign ovf_add = (reg1_i[MSB] == reg2_i[MSB]) && (sum[MSB] != reg1_i[MSB]);
    // operands of opposite sign, result takes the sign of reg2
    assign ovf_sub = (reg1_i[MSB] != reg2_i[MSB]) && (diff[MSB] != reg1_i[MSB]);

    assign eq   = (diff == `EX_ZERO_WORD);
    assign lt_u = borrow;
    // with differing signs the negative one is smaller
    assign lt_s = (reg1_i[MSB] != reg2_i[MSB]) ? reg1_i[MSB] : diff[MSB];

    always_comb
    begin
        arith_res_o = `EX_ZERO_WORD;
        ovf_o       = 1'b0;
        case (aluop_i)
            OP_ADD:
            begin
                arith_res_o = sum;
                ovf_o       = ovf_add;
            end
            OP_ADDU: arith_res_o = sum;
            OP_SUB:
            begin
                arith_res_o = diff;
                ovf_o       = ovf_sub;
            end
            OP_SUBU: arith_res_o = diff;
            OP_SLT:  arith_res_o = {{MSB{1'b0}}, lt_s};
            OP_SLTU: arith_res_o = {{MSB{1'b0}}, lt_u};
            default: arith_res_o = `EX_ZERO_WORD;
        endcase
    end

    always_comb
    begin
        case (aluop_i)
            OP_TEQ:  trap_o = eq;
            OP_TNE:  trap_o = !eq;
            OP_TGE:  trap_o = !lt_s;
            OP_TGEU: trap_o = !lt_u;
            OP_TLT:  trap_o = lt_s;
            OP_TLTU: trap_o = lt_u;
            default: trap_o = 1'b0;
        endcase
    end

endmodule

// File: src/mul_unit.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module mul_unit
    import ex_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  aluop_e                aluop_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    input  hilo_t                 hilo_i,
    output hilo_t                 prod_s_o,
    output hilo_t                 prod_u_o,
    output hilo_t                 acc_o,
    output logic                  stall_o
);

    localparam int MSB = `EX_DATA_W - 1;

    logic [`EX_DATA_W-1:0]   mag1;
    logic [`EX_DATA_W-1:0]   mag2;
    logic [2*`EX_DATA_W-1:0] mag_prod;
    logic                    neg;
    hilo_t                   prod_sel;
    hilo_t                   prod_q;
    mac_state_e              state_q;
    logic                    is_mac;
    logic                    is_msub;
    logic                    is_unsigned;

    // signed product from magnitudes, sign fixed afterwards
    assign mag1     = reg1_i[MSB] ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2     = reg2_i[MSB] ? (~reg2_i + 1'b1) : reg2_i;
    assign mag_prod = mag1 * mag2;
    assign neg      = reg1_i[MSB] ^ reg2_i[MSB];
    assign prod_s_o = neg ? (~mag_prod + 1'b1) : mag_prod;
    assign prod_u_o = reg1_i * reg2_i;

    assign is_mac      = (aluop_i == OP_MADD) || (aluop_i == OP_MADDU) ||
                         (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);
    assign is_msub     = (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);
    assign is_unsigned = (aluop_i == OP_MADDU) || (aluop_i == OP_MSUBU);
    assign prod_sel    = is_unsigned ? prod_u_o : prod_s_o;

    // first cycle holds the pipeline while the product is captured
    assign stall_o = is_mac && (state_q == MAC_MUL);

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            state_q <= MAC_MUL;
        else if (state_q == MAC_ACC)
            state_q <= MAC_MUL;
        else if (is_mac)
            state_q <= MAC_ACC;
    end

    always_ff @(posedge clk_i)
    begin
        if (stall_o)
            prod_q <= prod_sel;
    end

    assign acc_o = is_msub ? (hilo_i - prod_q) : (hilo_i + prod_q);

endmodule

// File: src/hilo_reg.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module hilo_reg
    import ex_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  we_i,
    input  hilo_t wdata_i,
    output hilo_t hilo_o
);

    hilo_t hilo_q;

    // both halves are always written together
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hilo_q.hi <= `EX_ZERO_WORD;
            hilo_q.lo <= `EX_ZERO_WORD;
        end
        else if (we_i)
        begin
            hilo_q <= wdata_i;
        end
    end

    assign hilo_o = hilo_q;

endmodule

// File: src/ex_stage.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  ex_op_t     op_i,
    output ex_wb_t     wb_o,
    output ex_except_t except_o,
    output logic       stallreq_o
);

    logic [`EX_DATA_W-1:0] logic_res;
    logic [`EX_DATA_W-1:0] shift_res;
    logic [`EX_DATA_W-1:0] arith_res;
    logic                  ovf;
    logic                  trap;
    hilo_t                 prod_s;
    hilo_t                 prod_u;
    hilo_t                 acc;
    hilo_t                 hilo_q;
    hilo_t                 hilo_d;
    logic                  hilo_wr;
    logic                  mac_stall;
    logic                  reg2_zero;

    alu_logic_shift u_logic_shift (
        .aluop_i     (op_i.aluop),
        .reg1_i      (op_i.reg1),
        .reg2_i      (op_i.reg2),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res)
    );

    alu_arith u_arith (
        .aluop_i     (op_i.aluop),
        .reg1_i      (op_i.reg1),
        .reg2_i      (op_i.reg2),
        .arith_res_o (arith_res),
        .ovf_o       (ovf),
        .trap_o      (trap)
    );

    mul_unit u_mul (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .aluop_i  (op_i.aluop),
        .reg1_i   (op_i.reg1),
        .reg2_i   (op_i.reg2),
        .hilo_i   (hilo_q),
        .prod_s_o (prod_s),
        .prod_u_o (prod_u),
        .acc_o    (acc),
        .stall_o  (mac_stall)
    );

    hilo_reg u_hilo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (hilo_wr && !mac_stall),
        .wdata_i (hilo_d),
        .hilo_o  (hilo_q)
    );

    assign stallreq_o = mac_stall;
    assign reg2_zero  = (op_i.reg2 == `EX_ZERO_WORD);

    // result mux by opcode group
    always_comb
    begin
        case (op_i.aluop)
            OP_AND, OP_OR, OP_XOR, OP_NOR:
                wb_o.wdata = logic_res;
            OP_SLL, OP_SRL, OP_SRA:
                wb_o.wdata = shift_res;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU:
                wb_o.wdata = arith_res;
            OP_MOVZ, OP_MOVN:
                wb_o.wdata = op_i.reg1;
            OP_MFHI: wb_o.wdata = hilo_q.hi;
            OP_MFLO: wb_o.wdata = hilo_q.lo;
            OP_MUL:  wb_o.wdata = prod_s.lo;
            default: wb_o.wdata = `EX_ZERO_WORD;
        endcase
    end

    // overflow and failed move conditions cancel the register write
    assign wb_o.wd   = op_i.wd;
    assign wb_o.wreg = op_i.wreg && !ovf &&
                       !((op_i.aluop == OP_MOVZ) && !reg2_zero) &&
                       !((op_i.aluop == OP_MOVN) && reg2_zero);

    assign except_o.trap     = trap;
    assign except_o.overflow = ovf;

    // next hi/lo value, written only once the stall has dropped
    always_comb
    begin
        hilo_wr = 1'b1;
        hilo_d  = hilo_q;
        case (op_i.aluop)
            OP_MTHI:  hilo_d.hi = op_i.reg1;
            OP_MTLO:  hilo_d.lo = op_i.reg1;
            OP_MULT:  hilo_d = prod_s;
            OP_MULTU: hilo_d = prod_u;
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU:
                hilo_d = acc;
            default:  hilo_wr = 1'b0;
        endcase
    end

endmodule

// File: sim/ex_ref.svh
`ifndef EX_REF_SVH
`define EX_REF_SVH

localparam int REF_MSB = `EX_DATA_W - 1;

typedef struct packed {
    ex_wb_t     wb;
    ex_except_t exc;
    logic       stall;
} ref_out_t;

// shadow of the stage's hi/lo pair and multiply-accumulate phase
hilo_t ref_hilo;
hilo_t ref_prod;
logic  ref_acc_phase;

function automatic logic is_mac_op(aluop_e op);
    return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
endfunction

function automatic hilo_t signed_product(logic [REF_MSB:0] a, logic [REF_MSB:0] b);
    logic signed [2*`EX_DATA_W-1:0] sa;
    logic signed [2*`EX_DATA_W-1:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    return sa * sb;
endfunction

function automatic hilo_t unsigned_product(logic [REF_MSB:0] a, logic [REF_MSB:0] b);
    return {{`EX_DATA_W{1'b0}}, a} * {{`EX_DATA_W{1'b0}}, b};
endfunction

// expected outputs for one cycle, given the op and the shadow state
function automatic ref_out_t ref_result(ex_op_t op, hilo_t hilo, logic acc_phase);
    ref_out_t           r;
    logic [REF_MSB:0]   a;
    logic [REF_MSB:0]   b;
    logic [REF_MSB+1:0] wide;
    logic [4:0]         sh;
    logic               move_ok;
    hilo_t              p;
    a       = op.reg1;
    b       = op.reg2;
    sh      = a[`EX_SHAMT_W-1:0];
    r       = '0;
    move_ok = 1'b1;
    case (op.aluop)
        OP_AND:  r.wb.wdata = a & b;
        OP_OR:   r.wb.wdata = a | b;
        OP_XOR:  r.wb.wdata = a ^ b;
        OP_NOR:  r.wb.wdata = ~a & ~b;
        OP_SLL:  r.wb.wdata = b << sh;
        OP_SRL:  r.wb.wdata = b >> sh;
        OP_SRA:  r.wb.wdata = b[REF_MSB] ? ~(~b >> sh) : (b >> sh);
        OP_ADD, OP_ADDU:
        begin
            wide           = {a[REF_MSB], a} + {b[REF_MSB], b};
            r.wb.wdata     = wide[REF_MSB:0];
            r.exc.overflow = (op.aluop == OP_ADD) && (wide[REF_MSB+1] != wide[REF_MSB]);
        end
        OP_SUB, OP_SUBU:
        begin
            wide           = {a[REF_MSB], a} - {b[REF_MSB], b};
            r.wb.wdata     = wide[REF_MSB:0];
            r.exc.overflow = (op.aluop == OP_SUB) && (wide[REF_MSB+1] != wide[REF_MSB]);
        end
        OP_SLT:  r.wb.wdata = ($signed(a) < $signed(b)) ? 1 : 0;
        OP_SLTU: r.wb.wdata = (a < b) ? 1 : 0;
        OP_MOVZ:
        begin
            r.wb.wdata = a;
            move_ok    = (b == 0);
        end
        OP_MOVN:
        begin
            r.wb.wdata = a;
            move_ok    = (b != 0);
        end
        OP_MFHI: r.wb.wdata = hilo.hi;
        OP_MFLO: r.wb.wdata = hilo.lo;
        OP_MUL:
        begin
            p          = signed_product(a, b);
            r.wb.wdata = p.lo;
        end
        OP_TEQ:  r.exc.trap = (a == b);
        OP_TNE:  r.exc.trap = (a != b);
        OP_TGE:  r.exc.trap = ($signed(a) >= $signed(b));
        OP_TGEU: r.exc.trap = (a >= b);
        OP_TLT:  r.exc.trap = ($signed(a) < $signed(b));
        OP_TLTU: r.exc.trap = (a < b);
        default: ;
    endcase
    r.wb.wd   = op.wd;
    r.wb.wreg = op.wreg && !r.exc.overflow && move_ok;
    r.stall   = is_mac_op(op.aluop) && !acc_phase;
    return r;
endfunction

task automatic ref_reset();
    ref_hilo      = '0;
    ref_prod      = '0;
    ref_acc_phase = 1'b0;
endtask

// advance the shadow across one rising edge
task automatic ref_step(ex_op_t op);
    if (is_mac_op(op.aluop) && !ref_acc_phase)
    begin
        // first cycle only captures the product
        if (op.aluop inside {OP_MADDU, OP_MSUBU})
            ref_prod = unsigned_product(op.reg1, op.reg2);
        else
            ref_prod = signed_product(op.reg1, op.reg2);
        ref_acc_phase = 1'b1;
    end
    else if (is_mac_op(op.aluop))
    begin
        // accumulator keeps the old hi/lo and adds or takes away the product
        if (op.aluop inside {OP_MSUB, OP_MSUBU})
            ref_hilo = ref_hilo - ref_prod;
        else
            ref_hilo = ref_hilo + ref_prod;
        ref_acc_phase = 1'b0;
    end
    else
    begin
        ref_acc_phase = 1'b0;
        case (op.aluop)
            OP_MTHI:  ref_hilo.hi = op.reg1;
            OP_MTLO:  ref_hilo.lo = op.reg1;
            OP_MULT:  ref_hilo = signed_product(op.reg1, op.reg2);
            OP_MULTU: ref_hilo = unsigned_product(op.reg1, op.reg2);
            default:  ;
        endcase
    end
endtask

`endif

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int HALF_PERIOD = 10;
    localparam int STALL_LIMIT = 8;

    logic       clk;
    logic       rst_n_i;
    ex_op_t     op_i;
    ex_wb_t     wb_o;
    ex_except_t except_o;
    logic       stallreq_o;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int fail_count  = 0;

    `include "ex_ref.svh"

    ex_stage UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n_i),
        .op_i       (op_i),
        .wb_o       (wb_o),
        .except_o   (except_o),
        .stallreq_o (stallreq_o)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic compare_value(string name, logic [REF_MSB:0] expected,
                                 logic [REF_MSB:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // sample just before the rising edge, then step the model across it
    always
    begin : compare_proc
        ref_out_t expected;
        @(negedge clk);
        #(HALF_PERIOD - 2);
        if (!rst_n_i)
        begin
            ref_reset();
        end
        else
        begin
            expected = ref_result(op_i, ref_hilo, ref_acc_phase);
            compare_value("wb_o.wdata", expected.wb.wdata, wb_o.wdata);
            compare_value("wb_o.wd", expected.wb.wd, wb_o.wd);
            compare_value("wb_o.wreg", expected.wb.wreg, wb_o.wreg);
            compare_value("except_o.trap", expected.exc.trap, except_o.trap);
            compare_value("except_o.overflow", expected.exc.overflow, except_o.overflow);
            compare_value("stallreq_o", expected.stall, stallreq_o);
            ref_step(op_i);
        end
    end

    task automatic drive_op(aluop_e op, logic [REF_MSB:0] a, logic [REF_MSB:0] b, logic wreg);
        @(negedge clk);
        op_i.aluop = op;
        op_i.reg1  = a;
        op_i.reg2  = b;
        op_i.wd    = $urandom_range(31, 0);
        op_i.wreg  = wreg;
    endtask

    task automatic read_hilo();
        drive_op(OP_MFHI, $urandom, $urandom, 1'b1);
        drive_op(OP_MFLO, $urandom, $urandom, 1'b1);
    endtask

    task automatic end_test(string name, int errors_before);
        drive_op(OP_NOP, '0, '0, 1'b0);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("%-12s PASS", name);
        end
        else
        begin
            fail_count++;
            $display("%-12s FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    // op stays on op_i while the stall is high
    task automatic run_mac(aluop_e op, logic [REF_MSB:0] a, logic [REF_MSB:0] b);
        int cycles;
        drive_op(op, a, b, 1'b1);
        #1;
        cycles = 0;
        while (stallreq_o && cycles < STALL_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (!stallreq_o)
        else
        begin
            $display("stall request for %s never dropped", op.name());
            error_count++;
        end
        assert (cycles == 1)
        else
        begin
            $display("stall request for %s lasted %0d cycles, not one", op.name(), cycles);
            error_count++;
        end
    endtask

    task automatic test_alu_random();
        aluop_e ops [11];
        int     e0;
        e0  = error_count;
        ops = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
                OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};
        repeat (200)
            drive_op(ops[$urandom_range(10, 0)], $urandom, $urandom, $urandom_range(1, 0));
        end_test("alu_random", e0);
    endtask

    task automatic test_overflow();
        int e0;
        e0 = error_count;
        drive_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        drive_op(OP_ADD, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        drive_op(OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b1);
        drive_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
        repeat (40)
            drive_op($urandom_range(1, 0) ? OP_ADD : OP_SUB, $urandom, $urandom, 1'b1);
        end_test("overflow", e0);
    endtask

    task automatic test_traps();
        aluop_e           ops [6];
        logic [REF_MSB:0] x;
        int               e0;
        e0  = error_count;
        ops = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
        foreach (ops[i])
        begin
            x = $urandom;
            drive_op(ops[i], x, x, 1'b0);
            drive_op(ops[i], 32'h8000_0000, 32'h0000_0001, 1'b0);
            drive_op(ops[i], 32'h0000_0001, 32'h8000_0000, 1'b0);
            drive_op(ops[i], 32'hffff_ffff, 32'h0000_0000, 1'b0);
            repeat (10)
                drive_op(ops[i], $urandom, $urandom, 1'b0);
        end
        end_test("traps", e0);
    endtask

    task automatic test_hilo_moves();
        int e0;
        e0 = error_count;
        repeat (4)
        begin
            drive_op(OP_MTHI, $urandom, $urandom, 1'b0);
            drive_op(OP_MTLO, $urandom, $urandom, 1'b0);
            read_hilo();
            drive_op(OP_MULT, $urandom, $urandom, 1'b0);
            read_hilo();
            drive_op(OP_MULTU, $urandom, $urandom, 1'b0);
            read_hilo();
            drive_op(OP_MUL, $urandom, $urandom, 1'b1);
        end
        end_test("hilo_moves", e0);
    endtask

    task automatic test_mac();
        aluop_e ops [4];
        int     e0;
        e0  = error_count;
        ops = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        foreach (ops[i])
        begin
            repeat (3)
            begin
                drive_op(OP_MTHI, $urandom, $urandom, 1'b0);
                drive_op(OP_MTLO, $urandom, $urandom, 1'b0);
                run_mac(ops[i], $urandom, $urandom);
                read_hilo();
            end
        end
        end_test("mac", e0);
    endtask

    task automatic test_cond_moves();
        int e0;
        e0 = error_count;
        repeat (20)
        begin
            drive_op(OP_MOVZ, $urandom, '0, 1'b1);
            drive_op(OP_MOVZ, $urandom, $urandom | 1, 1'b1);
            drive_op(OP_MOVN, $urandom, '0, 1'b1);
            drive_op(OP_MOVN, $urandom, $urandom | 1, 1'b1);
        end
        end_test("cond_moves", e0);
    endtask

    initial
    begin
        void'($urandom(32'h75117a3a));
        clk     = 1'b0;
        rst_n_i = 1'b0;
        // all-zero op is a NOP
        op_i    = '0;
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
        test_alu_random();
        test_overflow();
        test_traps();
        test_hilo_moves();
        test_mac();
        test_cond_moves();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, fail_count, check_count, error_count);
        if (fail_count == 0 && error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
+incdir+sim
src/ex_pkg.sv
src/alu_logic_shift.sv
src/alu_arith.sv
src/mul_unit.sv
src/hilo_reg.sv
src/ex_stage.sv
sim/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ex_pkg.sv
      - src/alu_logic_shift.sv
      - src/alu_arith.sv
      - src/mul_unit.sv
      - src/hilo_reg.sv
      - src/ex_stage.sv
  - target: simulation
    include_dirs:
      - src
      - sim
    files:
      - sim/tb_ex_stage.sv
